/* common/spm_pkg.sv */
package spm_pkg;

    // Default geometry of the scratchpad, overridden at spm_top
    localparam int DEF_ADDR_WIDTH = 8;        // Word address bits, 256 words
    localparam int DEF_NUM_COL = 4;           // Independently writable columns per word
    localparam int DEF_COL_WIDTH = 12;        // Pads to 16 bits inside the RAM wrapper

    // Read latency from b_en to b_rdata, also the depth of the tag pipeline
    localparam int DEF_PIPELINE_DEPTH = 2;

    localparam int DEF_CASCADE_DEPTH = 4;     // Max block RAM cascade height

    // Identifies which of the two clients owns a grant or a returning read
    // 0 is client 0, 1 is client 1
    typedef logic client_t;

endpackage

/* ram/sdp_ram.sv */
`timescale 1ns/1ps

module sdp_ram
    import spm_pkg::*;
#(
    parameter int ADDR_WIDTH = DEF_ADDR_WIDTH,
    parameter int NUM_COL = DEF_NUM_COL,
    parameter int COL_WIDTH = DEF_COL_WIDTH,
    parameter int PIPELINE_DEPTH = DEF_PIPELINE_DEPTH,   // Read latency, at least 1
    parameter int CASCADE_DEPTH = DEF_CASCADE_DEPTH,
    localparam int DATA_WIDTH = NUM_COL * COL_WIDTH
) (
    input  logic                  clk,
    // Write port
    input  logic                  a_en,
    input  logic [NUM_COL-1:0]    a_wbe,
    input  logic [DATA_WIDTH-1:0] a_wdata,
    input  logic [ADDR_WIDTH-1:0] a_addr,
    // Read port
    input  logic                  b_en,
    input  logic [ADDR_WIDTH-1:0] b_addr,
    output logic [DATA_WIDTH-1:0] b_rdata
);

    localparam int DEPTH = 2 ** ADDR_WIDTH;

    // Storage array, cascade height limited so timing stays reasonable on big arrays
    (* cascade_height = CASCADE_DEPTH *)
    logic [DATA_WIDTH-1:0] mem [DEPTH];

    // Output pipeline, stage 0 is the RAM's own read register
    logic [DATA_WIDTH-1:0] rd_pipe [PIPELINE_DEPTH];

    // Column writes, each enabled column lands independently
    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_COL; i++) begin
            if (a_en && a_wbe[i]) begin
                mem[a_addr][i*COL_WIDTH +: COL_WIDTH] <= a_wdata[i*COL_WIDTH +: COL_WIDTH];
            end
        end
    end

    // Read first, so a same-edge write to this address is not seen here
    always_ff @(posedge clk) begin
        if (b_en) begin
            rd_pipe[0] <= mem[b_addr];
        end
        for (int i = 1; i < PIPELINE_DEPTH; i++) begin
            rd_pipe[i] <= rd_pipe[i-1];   // Free-running extra output registers
        end
    end

    assign b_rdata = rd_pipe[PIPELINE_DEPTH-1];

    // An X address with the enable up would corrupt or read a random word
    a_wr_addr_known: assert property (
        @(posedge clk) a_en |-> !$isunknown(a_addr)
    ) else $error("sdp_ram: unknown write address while a_en is high");

    a_rd_addr_known: assert property (
        @(posedge clk) b_en |-> !$isunknown(b_addr)
    ) else $error("sdp_ram: unknown read address while b_en is high");

endmodule

/* ram/sdp_ram_padded.sv */
`timescale 1ns/1ps

module sdp_ram_padded
    import spm_pkg::*;
#(
    parameter int ADDR_WIDTH = DEF_ADDR_WIDTH,
    parameter int NUM_COL = DEF_NUM_COL,
    parameter int COL_WIDTH = DEF_COL_WIDTH,
    parameter int PIPELINE_DEPTH = DEF_PIPELINE_DEPTH,
    parameter int CASCADE_DEPTH = DEF_CASCADE_DEPTH,
    localparam int DATA_WIDTH = NUM_COL * COL_WIDTH
) (
    input  logic                  clk,
    input  logic                  a_en,
    input  logic [NUM_COL-1:0]    a_wbe,
    input  logic [DATA_WIDTH-1:0] a_wdata,
    input  logic [ADDR_WIDTH-1:0] a_addr,
    input  logic                  b_en,
    input  logic [ADDR_WIDTH-1:0] b_addr,
    output logic [DATA_WIDTH-1:0] b_rdata
);

    // Round each column up to a byte lane of 8 or 9 bits, whichever wastes less
    localparam int PAD8 = (8 - (COL_WIDTH % 8)) % 8;
    localparam int PAD9 = (9 - (COL_WIDTH % 9)) % 9;   // 9-bit lanes use the parity bits
    localparam int PAD = (PAD8 <= PAD9) ? PAD8 : PAD9;
    localparam int PCOL_WIDTH = COL_WIDTH + PAD;
    localparam int PDATA_WIDTH = NUM_COL * PCOL_WIDTH;

    generate
        if (PAD == 0 || NUM_COL == 1) begin : g_direct
            // Columns already line up with the byte enables
            sdp_ram #(
                .ADDR_WIDTH     (ADDR_WIDTH),
                .NUM_COL        (NUM_COL),
                .COL_WIDTH      (COL_WIDTH),
                .PIPELINE_DEPTH (PIPELINE_DEPTH),
                .CASCADE_DEPTH  (CASCADE_DEPTH)
            ) u_sdp_ram (
                .clk     (clk),
                .a_en    (a_en),
                .a_wbe   (a_wbe),
                .a_wdata (a_wdata),
                .a_addr  (a_addr),
                .b_en    (b_en),
                .b_addr  (b_addr),
                .b_rdata (b_rdata)
            );
        end else begin : g_padded
            logic [PDATA_WIDTH-1:0] a_wdata_pad;   // Write word with a zero pad above each column
            logic [PDATA_WIDTH-1:0] b_rdata_pad;

            always_comb begin
                a_wdata_pad = '0;
                for (int i = 0; i < NUM_COL; i++) begin
                    a_wdata_pad[i*PCOL_WIDTH +: COL_WIDTH] = a_wdata[i*COL_WIDTH +: COL_WIDTH];
                    b_rdata[i*COL_WIDTH +: COL_WIDTH] = b_rdata_pad[i*PCOL_WIDTH +: COL_WIDTH];
                end
            end

            sdp_ram #(
                .ADDR_WIDTH     (ADDR_WIDTH),
                .NUM_COL        (NUM_COL),
                .COL_WIDTH      (PCOL_WIDTH),
                .PIPELINE_DEPTH (PIPELINE_DEPTH),
                .CASCADE_DEPTH  (CASCADE_DEPTH)
            ) u_sdp_ram (
                .clk     (clk),
                .a_en    (a_en),
                .a_wbe   (a_wbe),
                .a_wdata (a_wdata_pad),
                .a_addr  (a_addr),
                .b_en    (b_en),
                .b_addr  (b_addr),
                .b_rdata (b_rdata_pad)
            );
        end
    endgenerate

endmodule

/* hdl/port_arbiter.sv */
`timescale 1ns/1ps

module port_arbiter
    import spm_pkg::*;
#(
    parameter int ADDR_WIDTH = DEF_ADDR_WIDTH,
    parameter int NUM_COL = DEF_NUM_COL,
    parameter int COL_WIDTH = DEF_COL_WIDTH,
    localparam int DATA_WIDTH = NUM_COL * COL_WIDTH
) (
    input  logic                  clk,
    input  logic                  rst,
    // Client 0 write
    input  logic                  c0_wr_req,
    input  logic [ADDR_WIDTH-1:0] c0_wr_addr,
    input  logic [NUM_COL-1:0]    c0_wbe,
    input  logic [DATA_WIDTH-1:0] c0_wr_data,
    output logic                  c0_wr_grant,
    // Client 1 write
    input  logic                  c1_wr_req,
    input  logic [ADDR_WIDTH-1:0] c1_wr_addr,
    input  logic [NUM_COL-1:0]    c1_wbe,
    input  logic [DATA_WIDTH-1:0] c1_wr_data,
    output logic                  c1_wr_grant,
    // Reads
    input  logic                  c0_rd_req,
    input  logic [ADDR_WIDTH-1:0] c0_rd_addr,
    output logic                  c0_rd_grant,
    input  logic                  c1_rd_req,
    input  logic [ADDR_WIDTH-1:0] c1_rd_addr,
    output logic                  c1_rd_grant,
    // RAM write port
    output logic                  a_en,
    output logic [NUM_COL-1:0]    a_wbe,
    output logic [DATA_WIDTH-1:0] a_wdata,
    output logic [ADDR_WIDTH-1:0] a_addr,
    // RAM read port and return tag
    output logic                  b_en,
    output logic [ADDR_WIDTH-1:0] b_addr,
    output logic                  rd_tag_en,
    output client_t               rd_tag
);

    client_t wr_last;   // Last write winner
    client_t rd_last;   // Last read winner
    client_t wr_win;
    client_t rd_win;

    // Contested grants go to the client not served last time
    function automatic client_t pick(input logic req0, input logic req1, input client_t last);
        if (req0 && req1) begin
            return ~last;
        end
        return client_t'(req1);
    endfunction

    assign wr_win = pick(c0_wr_req, c1_wr_req, wr_last);
    assign rd_win = pick(c0_rd_req, c1_rd_req, rd_last);

    assign c0_wr_grant = c0_wr_req && (wr_win == 1'b0);
    assign c1_wr_grant = c1_wr_req && (wr_win == 1'b1);
    assign c0_rd_grant = c0_rd_req && (rd_win == 1'b0);
    assign c1_rd_grant = c1_rd_req && (rd_win == 1'b1);

    // Winner's operands go straight to the RAM in the grant cycle
    assign a_en = c0_wr_req || c1_wr_req;
    assign a_wbe = wr_win ? c1_wbe : c0_wbe;
    assign a_wdata = wr_win ? c1_wr_data : c0_wr_data;
    assign a_addr = wr_win ? c1_wr_addr : c0_wr_addr;

    assign b_en = c0_rd_req || c1_rd_req;
    assign b_addr = rd_win ? c1_rd_addr : c0_rd_addr;
    assign rd_tag_en = b_en;   // Every read issued carries a tag
    assign rd_tag = rd_win;

    // Reset to client 1 as last winner so client 0 takes the first contest
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_last <= 1'b1;
            rd_last <= 1'b1;
        end else begin
            if (a_en) wr_last <= wr_win;
            if (b_en) rd_last <= rd_win;
        end
    end

    property p_grant_sane(logic g0, logic g1, logic r0, logic r1);
        !(g0 && g1) && (!g0 || r0) && (!g1 || r1);
    endproperty

    a_wr_grant_sane: assert property (@(posedge clk) disable iff (rst)
        p_grant_sane(c0_wr_grant, c1_wr_grant, c0_wr_req, c1_wr_req));

    a_rd_grant_sane: assert property (@(posedge clk) disable iff (rst)
        p_grant_sane(c0_rd_grant, c1_rd_grant, c0_rd_req, c1_rd_req));

endmodule

/* hdl/read_return.sv */
`timescale 1ns/1ps

module read_return
    import spm_pkg::*;
#(
    parameter int NUM_COL = DEF_NUM_COL,
    parameter int COL_WIDTH = DEF_COL_WIDTH,
    parameter int PIPELINE_DEPTH = DEF_PIPELINE_DEPTH,   // Must match the RAM latency
    localparam int DATA_WIDTH = NUM_COL * COL_WIDTH
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  rd_tag_en,     // A read was issued this cycle
    input  client_t               rd_tag,        // Owner of that read
    input  logic [DATA_WIDTH-1:0] b_rdata,
    output logic                  c0_rd_valid,
    output logic                  c1_rd_valid,
    output logic [DATA_WIDTH-1:0] rd_data
);

    logic    valid_pipe [PIPELINE_DEPTH];   // One slot per cycle of RAM latency
    client_t tag_pipe [PIPELINE_DEPTH];

    // Valid shift register, empty after reset
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < PIPELINE_DEPTH; i++) begin
                valid_pipe[i] <= 1'b0;
            end
        end else begin
            valid_pipe[0] <= rd_tag_en;
            for (int i = 1; i < PIPELINE_DEPTH; i++) begin
                valid_pipe[i] <= valid_pipe[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        tag_pipe[0] <= rd_tag;
        for (int i = 1; i < PIPELINE_DEPTH; i++) begin
            tag_pipe[i] <= tag_pipe[i-1];
        end
    end

    // Last stage lines up with b_rdata leaving the RAM
    assign c0_rd_valid = valid_pipe[PIPELINE_DEPTH-1] && (tag_pipe[PIPELINE_DEPTH-1] == 1'b0);
    assign c1_rd_valid = valid_pipe[PIPELINE_DEPTH-1] && (tag_pipe[PIPELINE_DEPTH-1] == 1'b1);
    assign rd_data = b_rdata;   // Valid pulse marks which client owns the shared bus

    a_one_owner: assert property (@(posedge clk) disable iff (rst)
        !(c0_rd_valid && c1_rd_valid));

endmodule

/* hdl/spm_top.sv */
`timescale 1ns/1ps

module spm_top
    import spm_pkg::*;
#(
    parameter int ADDR_WIDTH = DEF_ADDR_WIDTH,
    parameter int NUM_COL = DEF_NUM_COL,
    parameter int COL_WIDTH = DEF_COL_WIDTH,
    parameter int PIPELINE_DEPTH = DEF_PIPELINE_DEPTH,
    parameter int CASCADE_DEPTH = DEF_CASCADE_DEPTH,
    localparam int DATA_WIDTH = NUM_COL * COL_WIDTH
) (
    input  logic                  clk,
    input  logic                  rst,
    // Client 0
    input  logic                  c0_wr_req,
    input  logic [ADDR_WIDTH-1:0] c0_wr_addr,
    input  logic [NUM_COL-1:0]    c0_wbe,
    input  logic [DATA_WIDTH-1:0] c0_wr_data,
    output logic                  c0_wr_grant,
    input  logic                  c0_rd_req,
    input  logic [ADDR_WIDTH-1:0] c0_rd_addr,
    output logic                  c0_rd_grant,
    output logic                  c0_rd_valid,
    output logic [DATA_WIDTH-1:0] c0_rd_data,
    // Client 1
    input  logic                  c1_wr_req,
    input  logic [ADDR_WIDTH-1:0] c1_wr_addr,
    input  logic [NUM_COL-1:0]    c1_wbe,
    input  logic [DATA_WIDTH-1:0] c1_wr_data,
    output logic                  c1_wr_grant,
    input  logic                  c1_rd_req,
    input  logic [ADDR_WIDTH-1:0] c1_rd_addr,
    output logic                  c1_rd_grant,
    output logic                  c1_rd_valid,
    output logic [DATA_WIDTH-1:0] c1_rd_data
);

    logic                  a_en;
    logic [NUM_COL-1:0]    a_wbe;
    logic [DATA_WIDTH-1:0] a_wdata;
    logic [ADDR_WIDTH-1:0] a_addr;
    logic                  b_en;
    logic [ADDR_WIDTH-1:0] b_addr;
    logic [DATA_WIDTH-1:0] b_rdata;
    logic                  rd_tag_en;
    client_t               rd_tag;
    logic [DATA_WIDTH-1:0] rd_data;

    port_arbiter #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .NUM_COL    (NUM_COL),
        .COL_WIDTH  (COL_WIDTH)
    ) u_port_arbiter (.*);

    sdp_ram_padded #(
        .ADDR_WIDTH     (ADDR_WIDTH),
        .NUM_COL        (NUM_COL),
        .COL_WIDTH      (COL_WIDTH),
        .PIPELINE_DEPTH (PIPELINE_DEPTH),
        .CASCADE_DEPTH  (CASCADE_DEPTH)
    ) u_sdp_ram_padded (.*);

    read_return #(
        .NUM_COL        (NUM_COL),
        .COL_WIDTH      (COL_WIDTH),
        .PIPELINE_DEPTH (PIPELINE_DEPTH)
    ) u_read_return (.*);

    assign c0_rd_data = rd_data;   // Both clients see the bus, only one gets valid
    assign c1_rd_data = rd_data;

endmodule

/* tb/spm_tb.sv */
`timescale 1ns/1ps

module spm_tb
    import spm_pkg::*;
();

    localparam int ADDR_WIDTH = DEF_ADDR_WIDTH;
    localparam int NUM_COL = DEF_NUM_COL;
    localparam int COL_WIDTH = DEF_COL_WIDTH;
    localparam int PIPELINE_DEPTH = DEF_PIPELINE_DEPTH;
    localparam int DATA_WIDTH = NUM_COL * COL_WIDTH;
    localparam int DEPTH = 2 ** ADDR_WIDTH;
    localparam int ADDR_RANGE = 4;        // Few addresses so reads and writes collide often
    localparam int NUM_CYCLES = 3000;
    localparam int TIMEOUT = 64;

    logic clk;
    logic rst;

    // Client inputs indexed by client id
    logic                  wr_req [2];
    logic [ADDR_WIDTH-1:0] wr_addr [2];
    logic [NUM_COL-1:0]    wbe [2];
    logic [DATA_WIDTH-1:0] wr_data [2];
    logic                  rd_req [2];
    logic [ADDR_WIDTH-1:0] rd_addr [2];

    logic                  c0_wr_grant;
    logic                  c1_wr_grant;
    logic                  c0_rd_grant;
    logic                  c1_rd_grant;
    logic                  c0_rd_valid;
    logic                  c1_rd_valid;
    logic [DATA_WIDTH-1:0] c0_rd_data;
    logic [DATA_WIDTH-1:0] c1_rd_data;

    logic    wr_taken [2];   // Grant seen at the last rising edge
    logic    rd_taken [2];
    int      wr_wait [2];
    int      rd_wait [2];
    int      cycle;

    // Reference model state
    logic [COL_WIDTH-1:0]  model_mem [DEPTH][NUM_COL];
    client_t               wr_prio_m;          // Client that wins the next write contest
    client_t               rd_prio_m;
    client_t               exp_client_q [$];   // Outstanding reads in grant order
    int                    exp_due_q [$];
    logic [DATA_WIDTH-1:0] exp_data_q [$];

    spm_top u_spm_top (
        .clk         (clk),
        .rst         (rst),
        .c0_wr_req   (wr_req[0]),
        .c0_wr_addr  (wr_addr[0]),
        .c0_wbe      (wbe[0]),
        .c0_wr_data  (wr_data[0]),
        .c0_wr_grant (c0_wr_grant),
        .c0_rd_req   (rd_req[0]),
        .c0_rd_addr  (rd_addr[0]),
        .c0_rd_grant (c0_rd_grant),
        .c0_rd_valid (c0_rd_valid),
        .c0_rd_data  (c0_rd_data),
        .c1_wr_req   (wr_req[1]),
        .c1_wr_addr  (wr_addr[1]),
        .c1_wbe      (wbe[1]),
        .c1_wr_data  (wr_data[1]),
        .c1_wr_grant (c1_wr_grant),
        .c1_rd_req   (rd_req[1]),
        .c1_rd_addr  (rd_addr[1]),
        .c1_rd_grant (c1_rd_grant),
        .c1_rd_valid (c1_rd_valid),
        .c1_rd_data  (c1_rd_data)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;   // 40 ns period
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check_data(input string name, input logic [DATA_WIDTH-1:0] got,
                              input logic [DATA_WIDTH-1:0] exp);
        if (got !== exp) fail_run($sformatf("error at %0t: %s is %h, expected %h",
                                            $time, name, got, exp));
    endtask

    task automatic check_grant(input string name, input client_t got, input client_t exp);
        if (got !== exp) fail_run($sformatf("error at %0t: %s is %0d, expected %0d",
                                            $time, name, got, exp));
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) fail_run($sformatf("error at %0t: %s is %b, expected %b",
                                            $time, name, got, exp));
    endtask

    // Whole word as the model holds it
    function automatic logic [DATA_WIDTH-1:0] model_word(input logic [ADDR_WIDTH-1:0] addr);
        logic [DATA_WIDTH-1:0] word;
        for (int c = 0; c < NUM_COL; c++) begin
            word[c*COL_WIDTH +: COL_WIDTH] = model_mem[addr][c];
        end
        return word;
    endfunction

    // Checks every cycle against the model at the rising edge
    always @(posedge clk) begin : monitor
        logic                  wr_g [2];
        logic                  rd_g [2];
        logic                  rd_v [2];
        logic [DATA_WIDTH-1:0] rd_d [2];
        client_t               exp_wr_win;
        client_t               exp_rd_win;
        client_t               due_client;
        logic                  due_now;
        if (!rst) begin
            cycle++;
            wr_g[0] = c0_wr_grant;
            wr_g[1] = c1_wr_grant;
            rd_g[0] = c0_rd_grant;
            rd_g[1] = c1_rd_grant;
            rd_v[0] = c0_rd_valid;
            rd_v[1] = c1_rd_valid;
            rd_d[0] = c0_rd_data;
            rd_d[1] = c1_rd_data;

            // Oldest outstanding read either lands now or nothing does
            due_now = (exp_due_q.size() > 0) && (exp_due_q[0] == cycle);
            due_client = due_now ? exp_client_q[0] : client_t'(0);
            for (int n = 0; n < 2; n++) begin
                check_bit($sformatf("c%0d_rd_valid", n), rd_v[n],
                          due_now && (due_client == client_t'(n)));
            end
            if (due_now) begin
                check_data($sformatf("c%0d_rd_data", due_client), rd_d[due_client],
                           exp_data_q[0]);
                void'(exp_client_q.pop_front());
                void'(exp_due_q.pop_front());
                void'(exp_data_q.pop_front());
            end

            // Priority holder takes a contested port, a lone requester always wins
            if (wr_req[0] && wr_req[1]) exp_wr_win = wr_prio_m;
            else if (wr_req[1]) exp_wr_win = client_t'(1);
            else exp_wr_win = client_t'(0);
            if (rd_req[0] && rd_req[1]) exp_rd_win = rd_prio_m;
            else if (rd_req[1]) exp_rd_win = client_t'(1);
            else exp_rd_win = client_t'(0);
            for (int n = 0; n < 2; n++) begin
                if (!wr_req[n]) check_bit($sformatf("c%0d_wr_grant", n), wr_g[n], 1'b0);
                if (!rd_req[n]) check_bit($sformatf("c%0d_rd_grant", n), rd_g[n], 1'b0);
            end

            // Read recorded before the write so same-cycle reads see old data
            if (rd_req[0] || rd_req[1]) begin
                check_bit("c0_rd_grant ^ c1_rd_grant", rd_g[0] ^ rd_g[1], 1'b1);
                check_grant("read winner", client_t'(rd_g[1]), exp_rd_win);
                rd_prio_m = (exp_rd_win == client_t'(0)) ? client_t'(1) : client_t'(0);
                exp_client_q.push_back(exp_rd_win);
                exp_due_q.push_back(cycle + PIPELINE_DEPTH);
                exp_data_q.push_back(model_word(rd_addr[exp_rd_win]));
            end
            if (wr_req[0] || wr_req[1]) begin
                check_bit("c0_wr_grant ^ c1_wr_grant", wr_g[0] ^ wr_g[1], 1'b1);
                check_grant("write winner", client_t'(wr_g[1]), exp_wr_win);
                wr_prio_m = (exp_wr_win == client_t'(0)) ? client_t'(1) : client_t'(0);
                for (int c = 0; c < NUM_COL; c++) begin
                    if (wbe[exp_wr_win][c]) begin   // Disabled columns keep their value
                        model_mem[wr_addr[exp_wr_win]][c] =
                            wr_data[exp_wr_win][c*COL_WIDTH +: COL_WIDTH];
                    end
                end
            end
            for (int n = 0; n < 2; n++) begin
                wr_taken[n] = wr_g[n];
                rd_taken[n] = rd_g[n];
            end
        end
    end

    // Both clients write full words together and client 0 wins the first contest
    task automatic init_pair(input int k);
        int waited;
        for (int n = 0; n < 2; n++) begin
            wr_req[n] = 1'b1;
            wr_addr[n] = ADDR_WIDTH'(k + 2 * n);
            wbe[n] = '1;
            wr_data[n] = DATA_WIDTH'({$urandom, $urandom});
        end
        waited = 0;
        do begin
            @(negedge clk);
            for (int n = 0; n < 2; n++) begin
                if (wr_taken[n]) wr_req[n] = 1'b0;
            end
            waited++;
            if (waited >= TIMEOUT && (wr_req[0] || wr_req[1])) begin
                fail_run("initial write not granted within 64 cycles");
            end
        end while (wr_req[0] || wr_req[1]);
    endtask

    initial begin : stimulus
        int waited;
        void'($urandom(32'hecc1fab5));
        rst = 1'b1;
        cycle = 0;
        wr_prio_m = 1'b0;   // Client 0 has priority after reset
        rd_prio_m = 1'b0;
        for (int n = 0; n < 2; n++) begin
            wr_req[n] = 1'b0;
            wr_addr[n] = '0;
            wbe[n] = '0;
            wr_data[n] = '0;
            rd_req[n] = 1'b0;
            rd_addr[n] = '0;
            wr_taken[n] = 1'b0;
            rd_taken[n] = 1'b0;
            wr_wait[n] = 0;
            rd_wait[n] = 0;
        end
        repeat (10) @(negedge clk);
        rst = 1'b0;
        repeat (6) @(negedge clk);   // Idle cycles with every grant and valid low

        init_pair(0);   // Fills addresses 0 to 3
        init_pair(1);

        // Random traffic with each request held until its grant
        for (int i = 0; i < NUM_CYCLES; i++) begin
            @(negedge clk);
            for (int n = 0; n < 2; n++) begin
                if (wr_req[n] && !wr_taken[n]) begin
                    wr_wait[n]++;
                    if (wr_wait[n] >= TIMEOUT) fail_run("write request not granted in time");
                end else begin
                    wr_wait[n] = 0;
                    wr_req[n] = ($urandom % 4) != 0;
                    wr_addr[n] = ADDR_WIDTH'($urandom % ADDR_RANGE);
                    wbe[n] = NUM_COL'($urandom);   // Partial column writes
                    wr_data[n] = DATA_WIDTH'({$urandom, $urandom});
                end
                if (rd_req[n] && !rd_taken[n]) begin
                    rd_wait[n]++;
                    if (rd_wait[n] >= TIMEOUT) fail_run("read request not granted in time");
                end else begin
                    rd_wait[n] = 0;
                    rd_req[n] = ($urandom % 4) != 0;
                    rd_addr[n] = ADDR_WIDTH'($urandom % ADDR_RANGE);
                end
            end
        end

        // Drop everything and let the in-flight reads drain
        @(negedge clk);
        for (int n = 0; n < 2; n++) begin
            wr_req[n] = 1'b0;
            rd_req[n] = 1'b0;
        end
        waited = 0;
        while (exp_due_q.size() > 0) begin
            @(negedge clk);
            waited++;
            if (waited >= TIMEOUT) fail_run("read data still outstanding after 64 cycles");
        end
        repeat (4) @(negedge clk);
        $display("No errors");
        $finish;
    end

endmodule

/* list.f */
common/spm_pkg.sv
ram/sdp_ram.sv
ram/sdp_ram_padded.sv
hdl/port_arbiter.sv
hdl/read_return.sv
hdl/spm_top.sv
tb/spm_tb.sv
